//--- Makefile
TOP = tb_load_store_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/agu_queue.sv
`timescale 1ns/1ps

module agu_queue #(
	parameter int N_AGU = lsu_pkg::N_AGU,
	parameter int TAG_WIDTH = lsu_pkg::TAG_WIDTH,
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int IDX_WIDTH = 2
) (
	input logic clk,
	input logic reset,
	input logic issue_push,
	input logic is_store,
	input logic [ADDR_WIDTH-1:0] offset,
	input logic base_ready,
	input logic [TAG_WIDTH-1:0] base_tag,
	input logic [ADDR_WIDTH-1:0] base_value,
	input logic [IDX_WIDTH-1:0] target_index,
	input logic cdb_valid,
	input logic [TAG_WIDTH-1:0] cdb_tag,
	input lsu_pkg::data_t cdb_data,
	input logic load_pop,
	input logic store_pop,
	output logic full,
	output logic agu_valid,
	output logic agu_is_store,
	output logic [IDX_WIDTH-1:0] agu_index,
	output logic [ADDR_WIDTH-1:0] agu_addr
);
	lsu_pkg::agu_state_t state [N_AGU];
	logic kind [N_AGU]; // high for a store
	logic [IDX_WIDTH-1:0] index [N_AGU];
	logic [ADDR_WIDTH-1:0] offs [N_AGU];
	logic ready [N_AGU];
	logic [TAG_WIDTH-1:0] tag [N_AGU];
	logic [ADDR_WIDTH-1:0] value [N_AGU];

	lsu_pkg::agu_state_t state_nxt [N_AGU];
	logic kind_nxt [N_AGU];
	logic [IDX_WIDTH-1:0] index_nxt [N_AGU];
	logic [ADDR_WIDTH-1:0] offs_nxt [N_AGU];
	logic ready_nxt [N_AGU];
	logic [TAG_WIDTH-1:0] tag_nxt [N_AGU];
	logic [ADDR_WIDTH-1:0] value_nxt [N_AGU];
	int sel;

	// oldest entry with its base in hand
	always_comb begin
		agu_valid = 1'b0;
		sel = 0;
		for (int j = N_AGU - 1; j >= 0; j--) begin
			if (state[j] == lsu_pkg::waiting && ready[j]) begin
				agu_valid = 1'b1;
				sel = j;
			end
		end
	end

	assign agu_is_store = kind[sel];
	assign agu_index = index[sel];
	assign agu_addr = value[sel] + offs[sel];
	assign full = state[N_AGU-1] == lsu_pkg::waiting;

	always_comb begin
		int k;
		k = 0;
		for (int j = 0; j < N_AGU; j++) begin
			state_nxt[j] = lsu_pkg::free;
			kind_nxt[j] = kind[j];
			index_nxt[j] = index[j];
			offs_nxt[j] = offs[j];
			ready_nxt[j] = ready[j];
			tag_nxt[j] = tag[j];
			value_nxt[j] = value[j];
		end
		// squeeze out the dispatched entry
		for (int j = 0; j < N_AGU; j++) begin
			if (state[j] == lsu_pkg::waiting && !(agu_valid && sel == j)) begin
				state_nxt[k] = lsu_pkg::waiting;
				kind_nxt[k] = kind[j];
				index_nxt[k] = index[j] - IDX_WIDTH'(kind[j] ? store_pop : load_pop);
				offs_nxt[k] = offs[j];
				ready_nxt[k] = ready[j] || (cdb_valid && cdb_tag == tag[j]);
				tag_nxt[k] = tag[j];
				value_nxt[k] = ready[j] ? value[j] : cdb_data[ADDR_WIDTH-1:0];
				k++;
			end
		end
		if (issue_push && k < N_AGU) begin
			state_nxt[k] = lsu_pkg::waiting;
			kind_nxt[k] = is_store;
			index_nxt[k] = target_index;
			offs_nxt[k] = offset;
			ready_nxt[k] = base_ready || (cdb_valid && cdb_tag == base_tag);
			tag_nxt[k] = base_tag;
			value_nxt[k] = base_ready ? base_value : cdb_data[ADDR_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < N_AGU; j++) begin
			state[j] <= reset ? lsu_pkg::free : state_nxt[j];
			kind[j] <= kind_nxt[j];
			index[j] <= index_nxt[j];
			offs[j] <= offs_nxt[j];
			ready[j] <= ready_nxt[j];
			tag[j] <= tag_nxt[j];
			value[j] <= value_nxt[j];
		end
	end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH
) (
	input logic clk,
	input logic we,
	input logic [ADDR_WIDTH-1:0] wr_addr,
	input lsu_pkg::data_t wr_data,
	input logic [ADDR_WIDTH-1:0] rd_addr,
	output lsu_pkg::data_t rd_data
);
	lsu_pkg::data_t mem [2**ADDR_WIDTH];

	initial begin
		for (int i = 0; i < 2**ADDR_WIDTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr]; // old data on a same-address write
	end

endmodule

//--- logic/load_queue.sv
`timescale 1ns/1ps

module load_queue #(
	parameter int N_LOAD = lsu_pkg::N_LOAD,
	parameter int N_STORE = lsu_pkg::N_STORE,
	parameter int TAG_WIDTH = lsu_pkg::TAG_WIDTH,
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int IDX_WIDTH = 2,
	localparam int LCW = $clog2(N_LOAD + 1),
	localparam int SCW = $clog2(N_STORE + 1)
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic absolute,
	input logic [ADDR_WIDTH-1:0] offset,
	input logic [TAG_WIDTH-1:0] dest_tag,
	input logic [SCW-1:0] older_stores,
	input logic agu_valid,
	input logic agu_is_store,
	input logic [IDX_WIDTH-1:0] agu_index,
	input logic [ADDR_WIDTH-1:0] agu_addr,
	input logic store_pop,
	input logic [ADDR_WIDTH-1:0] st_addr [N_STORE],
	input lsu_pkg::data_t st_data [N_STORE],
	input logic [N_STORE-1:0] st_known,
	input lsu_pkg::data_t ram_rd_data,
	input logic result_ready,
	output logic full,
	output logic [LCW-1:0] load_count,
	output logic load_pop,
	output logic [ADDR_WIDTH-1:0] ram_rd_addr,
	output logic result_valid,
	output logic [TAG_WIDTH-1:0] result_tag,
	output lsu_pkg::data_t result_data
);
	logic [TAG_WIDTH-1:0] tag [N_LOAD];
	logic [ADDR_WIDTH-1:0] addr [N_LOAD];
	logic known [N_LOAD];
	logic [SCW-1:0] older [N_LOAD]; // stores ahead of this load

	logic [TAG_WIDTH-1:0] tag_nxt [N_LOAD];
	logic [ADDR_WIDTH-1:0] addr_nxt [N_LOAD];
	logic known_nxt [N_LOAD];
	logic [SCW-1:0] older_nxt [N_LOAD];

	logic stores_known;
	logic fwd_hit_c;
	lsu_pkg::data_t fwd_data_c;
	logic rd_pending; // ram read in flight
	logic fwd_hit;
	lsu_pkg::data_t fwd_data;
	logic [TAG_WIDTH-1:0] pend_tag;

	// disambiguation and forwarding for the head load
	always_comb begin
		stores_known = 1'b1;
		fwd_hit_c = 1'b0;
		fwd_data_c = st_data[0];
		for (int i = 0; i < N_STORE; i++) begin
			if (SCW'(i) < older[0]) begin
				if (!st_known[i])
					stores_known = 1'b0;
				if (st_addr[i] == addr[0]) begin
					fwd_hit_c = 1'b1; // later hits are younger
					fwd_data_c = st_data[i];
				end
			end
		end
	end

	assign load_pop = load_count != '0 && known[0] && stores_known && !rd_pending &&
		(!result_valid || result_ready);
	assign ram_rd_addr = addr[0];
	assign full = load_count == LCW'(N_LOAD);

	always_comb begin
		int k;
		k = 0;
		for (int j = 0; j < N_LOAD; j++) begin
			tag_nxt[j] = tag[j];
			addr_nxt[j] = addr[j];
			known_nxt[j] = known[j];
			older_nxt[j] = older[j];
		end
		for (int j = 0; j < N_LOAD; j++) begin
			if (LCW'(j) < load_count && !(load_pop && j == 0)) begin
				tag_nxt[k] = tag[j];
				if (agu_valid && !agu_is_store && agu_index == IDX_WIDTH'(j)) begin
					addr_nxt[k] = agu_addr;
					known_nxt[k] = 1'b1;
				end else begin
					addr_nxt[k] = addr[j];
					known_nxt[k] = known[j];
				end
				older_nxt[k] = older[j] - SCW'(store_pop && older[j] != '0);
				k++;
			end
		end
		if (push && k < N_LOAD) begin
			tag_nxt[k] = dest_tag;
			addr_nxt[k] = offset; // absolute address, or filled in by the agu
			known_nxt[k] = absolute;
			older_nxt[k] = older_stores;
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < N_LOAD; j++) begin
			tag[j] <= tag_nxt[j];
			addr[j] <= addr_nxt[j];
			known[j] <= known_nxt[j];
			older[j] <= older_nxt[j];
		end
		load_count <= reset ? '0 : load_count - LCW'(load_pop) + LCW'(push);
		rd_pending <= reset ? 1'b0 : load_pop;
		if (reset)
			result_valid <= 1'b0;
		else if (rd_pending)
			result_valid <= 1'b1;
		else if (result_ready)
			result_valid <= 1'b0;
		if (load_pop) begin
			pend_tag <= tag[0];
			fwd_hit <= fwd_hit_c;
			fwd_data <= fwd_data_c;
		end
		if (rd_pending) begin
			result_tag <= pend_tag;
			result_data <= fwd_hit ? fwd_data : ram_rd_data;
		end
	end

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit #(
	parameter int TAG_WIDTH = lsu_pkg::TAG_WIDTH,
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int N_AGU = lsu_pkg::N_AGU,
	parameter int N_LOAD = lsu_pkg::N_LOAD,
	parameter int N_STORE = lsu_pkg::N_STORE
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic issue_is_store,
	input logic issue_absolute,
	input logic [ADDR_WIDTH-1:0] issue_offset,
	input logic issue_base_ready,
	input logic [TAG_WIDTH-1:0] issue_base_tag,
	input logic [ADDR_WIDTH-1:0] issue_base_value,
	input logic [TAG_WIDTH-1:0] issue_dest_tag,
	input logic issue_data_ready,
	input logic [TAG_WIDTH-1:0] issue_data_tag,
	input lsu_pkg::data_t issue_data_value,
	output logic issue_ready,
	input logic cdb_valid,
	input logic [TAG_WIDTH-1:0] cdb_tag,
	input lsu_pkg::data_t cdb_data,
	output logic result_valid,
	output logic [TAG_WIDTH-1:0] result_tag,
	output lsu_pkg::data_t result_data,
	input logic result_ready,
	output logic commit_ready,
	input logic commit_valid
);
	localparam int IDX_WIDTH = $clog2(N_STORE > N_LOAD ? N_STORE : N_LOAD);
	localparam int LCW = $clog2(N_LOAD + 1);
	localparam int SCW = $clog2(N_STORE + 1);

	logic accept;
	logic agu_full, load_full, store_full;
	logic agu_valid, agu_is_store;
	logic [IDX_WIDTH-1:0] agu_index, target_index;
	logic [ADDR_WIDTH-1:0] agu_addr;
	logic [LCW-1:0] load_count;
	logic [SCW-1:0] store_count;
	logic load_pop, store_pop;
	logic [ADDR_WIDTH-1:0] st_addr [N_STORE];
	lsu_pkg::data_t st_data [N_STORE];
	logic [N_STORE-1:0] st_known;
	logic ram_we;
	logic [ADDR_WIDTH-1:0] ram_wr_addr, ram_rd_addr;
	lsu_pkg::data_t ram_wr_data, ram_rd_data;

	// a slot counts as free if its occupant leaves this cycle
	assign issue_ready = (issue_absolute || !agu_full || agu_valid) &&
		(issue_is_store ? (!store_full || store_pop) : (!load_full || load_pop));
	assign accept = issue_valid && issue_ready;
	assign target_index = issue_is_store ? IDX_WIDTH'(store_count - SCW'(store_pop)) :
		IDX_WIDTH'(load_count - LCW'(load_pop));

	agu_queue #(
		.N_AGU(N_AGU), .TAG_WIDTH(TAG_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .IDX_WIDTH(IDX_WIDTH)
	) agu_queue_i (
		.clk(clk), .reset(reset),
		.issue_push(accept && !issue_absolute), .is_store(issue_is_store),
		.offset(issue_offset), .base_ready(issue_base_ready), .base_tag(issue_base_tag),
		.base_value(issue_base_value), .target_index(target_index),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.load_pop(load_pop), .store_pop(store_pop), .full(agu_full),
		.agu_valid(agu_valid), .agu_is_store(agu_is_store), .agu_index(agu_index),
		.agu_addr(agu_addr)
	);

	load_queue #(
		.N_LOAD(N_LOAD), .N_STORE(N_STORE), .TAG_WIDTH(TAG_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH), .IDX_WIDTH(IDX_WIDTH)
	) load_queue_i (
		.clk(clk), .reset(reset),
		.push(accept && !issue_is_store), .absolute(issue_absolute), .offset(issue_offset),
		.dest_tag(issue_dest_tag), .older_stores(store_count - SCW'(store_pop)),
		.agu_valid(agu_valid), .agu_is_store(agu_is_store), .agu_index(agu_index),
		.agu_addr(agu_addr), .store_pop(store_pop),
		.st_addr(st_addr), .st_data(st_data), .st_known(st_known),
		.ram_rd_data(ram_rd_data), .result_ready(result_ready),
		.full(load_full), .load_count(load_count), .load_pop(load_pop),
		.ram_rd_addr(ram_rd_addr), .result_valid(result_valid), .result_tag(result_tag),
		.result_data(result_data)
	);

	store_queue #(
		.N_STORE(N_STORE), .TAG_WIDTH(TAG_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
		.IDX_WIDTH(IDX_WIDTH)
	) store_queue_i (
		.clk(clk), .reset(reset),
		.push(accept && issue_is_store), .absolute(issue_absolute), .offset(issue_offset),
		.data_ready(issue_data_ready), .data_tag(issue_data_tag),
		.data_value(issue_data_value),
		.agu_valid(agu_valid), .agu_is_store(agu_is_store), .agu_index(agu_index),
		.agu_addr(agu_addr),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.commit_valid(commit_valid), .full(store_full), .store_count(store_count),
		.store_pop(store_pop), .commit_ready(commit_ready),
		.st_addr(st_addr), .st_data(st_data), .st_known(st_known),
		.ram_we(ram_we), .ram_wr_addr(ram_wr_addr), .ram_wr_data(ram_wr_data)
	);

	data_ram #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) data_ram_i (
		.clk(clk), .we(ram_we), .wr_addr(ram_wr_addr), .wr_data(ram_wr_data),
		.rd_addr(ram_rd_addr), .rd_data(ram_rd_data)
	);

endmodule

//--- logic/lsu_pkg.sv
package lsu_pkg;

	// default widths, overridden by the top level parameters
	localparam int TAG_WIDTH = 4;
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;

	typedef logic [TAG_WIDTH-1:0] tag_t;   // reorder buffer tag
	typedef logic [ADDR_WIDTH-1:0] addr_t; // word address into data ram
	typedef logic [DATA_WIDTH-1:0] data_t;

	// default queue depths
	localparam int N_AGU = 2;
	localparam int N_LOAD = 2;
	localparam int N_STORE = 4;

	typedef enum logic {
		free,
		waiting
	} agu_state_t;

endpackage

//--- logic/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
	parameter int N_STORE = lsu_pkg::N_STORE,
	parameter int TAG_WIDTH = lsu_pkg::TAG_WIDTH,
	parameter int ADDR_WIDTH = lsu_pkg::ADDR_WIDTH,
	parameter int IDX_WIDTH = 2,
	localparam int SCW = $clog2(N_STORE + 1)
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic absolute,
	input logic [ADDR_WIDTH-1:0] offset,
	input logic data_ready,
	input logic [TAG_WIDTH-1:0] data_tag,
	input lsu_pkg::data_t data_value,
	input logic agu_valid,
	input logic agu_is_store,
	input logic [IDX_WIDTH-1:0] agu_index,
	input logic [ADDR_WIDTH-1:0] agu_addr,
	input logic cdb_valid,
	input logic [TAG_WIDTH-1:0] cdb_tag,
	input lsu_pkg::data_t cdb_data,
	input logic commit_valid,
	output logic full,
	output logic [SCW-1:0] store_count,
	output logic store_pop,
	output logic commit_ready,
	output logic [ADDR_WIDTH-1:0] st_addr [N_STORE],
	output lsu_pkg::data_t st_data [N_STORE],
	output logic [N_STORE-1:0] st_known,
	output logic ram_we,
	output logic [ADDR_WIDTH-1:0] ram_wr_addr,
	output lsu_pkg::data_t ram_wr_data
);
	logic addr_known [N_STORE];
	logic data_known [N_STORE];
	logic [TAG_WIDTH-1:0] dtag [N_STORE];

	logic [ADDR_WIDTH-1:0] addr_nxt [N_STORE];
	lsu_pkg::data_t data_nxt [N_STORE];
	logic addr_known_nxt [N_STORE];
	logic data_known_nxt [N_STORE];
	logic [TAG_WIDTH-1:0] dtag_nxt [N_STORE];

	always_comb begin
		for (int i = 0; i < N_STORE; i++)
			st_known[i] = SCW'(i) < store_count && addr_known[i] && data_known[i];
	end

	assign commit_ready = st_known[0];
	assign store_pop = commit_valid && commit_ready;
	assign ram_we = store_pop;
	assign ram_wr_addr = st_addr[0];
	assign ram_wr_data = st_data[0];
	assign full = store_count == SCW'(N_STORE);

	always_comb begin
		int k;
		k = 0;
		for (int j = 0; j < N_STORE; j++) begin
			addr_nxt[j] = st_addr[j];
			data_nxt[j] = st_data[j];
			addr_known_nxt[j] = addr_known[j];
			data_known_nxt[j] = data_known[j];
			dtag_nxt[j] = dtag[j];
		end
		for (int j = 0; j < N_STORE; j++) begin
			if (SCW'(j) < store_count && !(store_pop && j == 0)) begin
				if (agu_valid && agu_is_store && agu_index == IDX_WIDTH'(j)) begin
					addr_nxt[k] = agu_addr;
					addr_known_nxt[k] = 1'b1;
				end else begin
					addr_nxt[k] = st_addr[j];
					addr_known_nxt[k] = addr_known[j];
				end
				// snoop the cdb for missing store data
				data_known_nxt[k] = data_known[j] || (cdb_valid && cdb_tag == dtag[j]);
				data_nxt[k] = data_known[j] ? st_data[j] : cdb_data;
				dtag_nxt[k] = dtag[j];
				k++;
			end
		end
		if (push && k < N_STORE) begin
			addr_nxt[k] = offset;
			addr_known_nxt[k] = absolute;
			data_known_nxt[k] = data_ready || (cdb_valid && cdb_tag == data_tag);
			data_nxt[k] = data_ready ? data_value : cdb_data;
			dtag_nxt[k] = data_tag;
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < N_STORE; j++) begin
			st_addr[j] <= addr_nxt[j];
			st_data[j] <= data_nxt[j];
			addr_known[j] <= addr_known_nxt[j];
			data_known[j] <= data_known_nxt[j];
			dtag[j] <= dtag_nxt[j];
		end
		store_count <= reset ? '0 : store_count - SCW'(store_pop) + SCW'(push);
	end

endmodule

//--- src.f
+incdir+verification
logic/lsu_pkg.sv
logic/agu_queue.sv
logic/load_queue.sv
logic/store_queue.sv
logic/data_ram.sv
logic/load_store_unit.sv
verification/tb_load_store_unit.sv

//--- verification/lsu_ref_model.svh
`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

// memory image in program order, one word per address
lsu_pkg::data_t model_mem [2**lsu_pkg::ADDR_WIDTH];

// expected load results, oldest load first
lsu_pkg::tag_t exp_tag [$];
lsu_pkg::data_t exp_data [$];

int stores_issued = 0;

function automatic void model_clear();
	for (int i = 0; i < 2**lsu_pkg::ADDR_WIDTH; i++)
		model_mem[i] = '0;
	exp_tag.delete();
	exp_data.delete();
	stores_issued = 0;
endfunction

// a store overwrites the word for every later load
function automatic void model_store(input lsu_pkg::addr_t addr, input lsu_pkg::data_t data);
	model_mem[addr] = data;
	stores_issued++;
endfunction

// latest earlier store wins, zero if none
function automatic void model_load(input lsu_pkg::addr_t addr, input lsu_pkg::tag_t tag);
	exp_tag.push_back(tag);
	exp_data.push_back(model_mem[addr]);
endfunction

`endif

//--- verification/tb_load_store_unit.sv
`timescale 1ns/1ps

module tb_load_store_unit;

	localparam int TW = lsu_pkg::TAG_WIDTH;
	localparam int AW = lsu_pkg::ADDR_WIDTH;
	localparam int ISSUE_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 2000;

	logic clk;
	logic reset;
	logic issue_valid, issue_is_store, issue_absolute;
	lsu_pkg::addr_t issue_offset, issue_base_value;
	logic issue_base_ready;
	lsu_pkg::tag_t issue_base_tag, issue_dest_tag, issue_data_tag;
	logic issue_data_ready;
	lsu_pkg::data_t issue_data_value;
	logic issue_ready;
	logic cdb_valid;
	lsu_pkg::tag_t cdb_tag;
	lsu_pkg::data_t cdb_data;
	logic result_valid;
	lsu_pkg::tag_t result_tag;
	lsu_pkg::data_t result_data;
	logic result_ready;
	logic commit_ready, commit_valid;

	// operands the cdb still owes the unit
	lsu_pkg::tag_t pend_tag [$];
	lsu_pkg::data_t pend_val [$];

	// loads issued ahead of each store not yet committed
	int loads_before [$];

	int errors = 0;
	int results = 0;
	int commits = 0;
	int commit_mode = 0; // 0 never, 1 always, 2 random
	int ready_left = 0;
	bit ready_random = 1'b0;
	bit cdb_hold = 1'b0;
	bit held = 1'b0;
	lsu_pkg::tag_t held_tag;
	lsu_pkg::data_t held_data;

	`include "lsu_ref_model.svh"

	load_store_unit #(
		.TAG_WIDTH(TW), .ADDR_WIDTH(AW), .N_AGU(lsu_pkg::N_AGU),
		.N_LOAD(lsu_pkg::N_LOAD), .N_STORE(lsu_pkg::N_STORE)
	) load_store_unit_i (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_is_store(issue_is_store),
		.issue_absolute(issue_absolute), .issue_offset(issue_offset),
		.issue_base_ready(issue_base_ready), .issue_base_tag(issue_base_tag),
		.issue_base_value(issue_base_value), .issue_dest_tag(issue_dest_tag),
		.issue_data_ready(issue_data_ready), .issue_data_tag(issue_data_tag),
		.issue_data_value(issue_data_value), .issue_ready(issue_ready),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.result_valid(result_valid), .result_tag(result_tag), .result_data(result_data),
		.result_ready(result_ready), .commit_ready(commit_ready), .commit_valid(commit_valid)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic finish_run();
		$display("results checked %0d, stores committed %0d, errors %0d", results, commits,
			errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	// a tag no outstanding operand uses and not on the cdb right now
	function automatic lsu_pkg::tag_t pick_tag(input bit avoid_en, input lsu_pkg::tag_t avoid);
		lsu_pkg::tag_t t;
		bit clash;
		t = TW'($urandom);
		for (int n = 0; n < 2**TW; n++) begin
			clash = (cdb_valid && cdb_tag == t) || (avoid_en && avoid == t);
			foreach (pend_tag[i])
				if (pend_tag[i] == t)
					clash = 1'b1;
			if (!clash)
				return t;
			t++;
		end
		return t;
	endfunction

	// drives cdb, commits and result back-pressure once per falling edge
	task automatic drive_background();
		int k;
		bit commit_ok;
		cdb_valid = 1'b0;
		if (!cdb_hold && pend_tag.size() > 0 && $urandom % 2 == 0) begin
			k = $urandom % pend_tag.size();
			cdb_valid = 1'b1;
			cdb_tag = pend_tag[k];
			cdb_data = pend_val[k];
			pend_tag.delete(k);
			pend_val.delete(k);
		end
		// rob order: a store retires only once every older load has answered
		commit_ok = 1'b0;
		if (loads_before.size() > 0)
			commit_ok = results >= loads_before[0];
		case (commit_mode)
			0: commit_valid = 1'b0;
			1: commit_valid = commit_ok;
			default: commit_valid = commit_ok && $urandom % 3 != 0;
		endcase
		if (!ready_random) begin
			result_ready = 1'b1;
		end else begin
			if (ready_left == 0) begin
				result_ready = $urandom % 2 == 0;
				ready_left = 1 + $urandom % 8; // stretch length
			end
			ready_left--;
		end
	endtask

	task automatic check_result();
		lsu_pkg::tag_t etag;
		lsu_pkg::data_t edata;
		assert (exp_tag.size() > 0) else begin
			$display("%0t: result returned with no load outstanding", $time);
			errors++;
		end
		if (exp_tag.size() > 0) begin
			etag = exp_tag.pop_front();
			edata = exp_data.pop_front();
			assert (result_tag == etag) else begin
				$display("FAIL %0t result_tag: got %h expected %h", $time, result_tag, etag);
				errors++;
			end
			assert (result_data == edata) else begin
				$display("FAIL %0t result_data: got %h expected %h", $time, result_data, edata);
				errors++;
			end
			results++;
		end
	endtask

	// outputs are stable from here up to the rising edge
	task automatic sample_outputs();
		if (commit_valid && commit_ready) begin
			commits++;
			void'(loads_before.pop_front());
		end
		if (held) begin
			assert (result_valid) else begin
				$display("FAIL %0t result_valid: got 0 expected 1", $time);
				errors++;
			end
			assert (result_tag == held_tag) else begin
				$display("FAIL %0t result_tag: got %h expected %h", $time, result_tag, held_tag);
				errors++;
			end
			assert (result_data == held_data) else begin
				$display("FAIL %0t result_data: got %h expected %h", $time, result_data,
					held_data);
				errors++;
			end
		end
		if (result_valid && result_ready)
			check_result();
		held = result_valid && !result_ready;
		held_tag = result_tag;
		held_data = result_data;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		issue_valid = 1'b0;
		drive_background();
		#1;
		sample_outputs();
	endtask

	task automatic issue_op(input bit is_store, input bit absolute, input lsu_pkg::addr_t addr,
		input lsu_pkg::data_t data, input bit base_late, input bit data_late,
		input lsu_pkg::tag_t dest);
		lsu_pkg::addr_t base;
		lsu_pkg::data_t word;
		bit accepted;
		int waited;
		base = AW'($urandom);
		@(negedge clk);
		drive_background();
		issue_valid = 1'b1;
		issue_is_store = is_store;
		issue_absolute = absolute;
		issue_offset = absolute ? addr : addr - base; // base + offset lands on addr
		issue_base_ready = absolute || !base_late;
		issue_base_value = base;
		issue_base_tag = issue_base_ready ? TW'($urandom) : pick_tag(1'b0, '0);
		issue_dest_tag = dest;
		issue_data_ready = !is_store || !data_late;
		issue_data_value = issue_data_ready ? data : $urandom;
		issue_data_tag = issue_data_ready ? TW'($urandom) :
			pick_tag(!issue_base_ready, issue_base_tag);
		if (is_store) begin
			loads_before.push_back(results + exp_tag.size());
			model_store(addr, data);
		end else begin
			model_load(addr, dest);
		end
		accepted = 1'b0;
		for (waited = 0; waited < ISSUE_TIMEOUT && !accepted; waited++) begin
			if (waited > 0) begin
				@(negedge clk);
				drive_background();
			end
			#1;
			accepted = issue_ready;
			sample_outputs();
		end
		assert (accepted) else begin
			$display("%0t: issue port never accepted the op", $time);
			errors++;
		end
		if (!accepted) begin
			finish_run();
		end else begin
			if (!issue_base_ready) begin
				word = $urandom; // upper bits are ignored by the agu
				word[AW-1:0] = base;
				pend_tag.push_back(issue_base_tag);
				pend_val.push_back(word);
			end
			if (!issue_data_ready) begin
				pend_tag.push_back(issue_data_tag);
				pend_val.push_back(data);
			end
		end
	endtask

	task automatic wait_drained(input bit with_stores);
		int n;
		bit done;
		done = 1'b0;
		for (n = 0; n < DRAIN_TIMEOUT && !done; n++) begin
			idle_cycle();
			done = exp_tag.size() == 0 && (!with_stores || commits == stores_issued);
		end
		assert (done) else begin
			$display("%0t: timed out with %0d loads and %0d stores outstanding", $time,
				exp_tag.size(), stores_issued - commits);
			errors++;
		end
		if (!done)
			finish_run();
	endtask

	initial begin
		bit st, ab, bl, dl;
		lsu_pkg::addr_t a;
		lsu_pkg::data_t d;
		void'($urandom(32'h38d2));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_is_store = 1'b0;
		issue_absolute = 1'b1;
		issue_offset = '0;
		issue_base_ready = 1'b1;
		issue_base_tag = '0;
		issue_base_value = '0;
		issue_dest_tag = '0;
		issue_data_ready = 1'b1;
		issue_data_tag = '0;
		issue_data_value = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		result_ready = 1'b1;
		commit_valid = 1'b0;
		model_clear();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		#1;
		assert (!result_valid) else begin
			$display("FAIL %0t result_valid: got %b expected 0", $time, result_valid);
			errors++;
		end
		assert (!commit_ready) else begin
			$display("FAIL %0t commit_ready: got %b expected 0", $time, commit_ready);
			errors++;
		end
		assert (issue_ready) else begin
			$display("FAIL %0t issue_ready: got %b expected 1", $time, issue_ready);
			errors++;
		end

		// untouched addresses read as zero
		for (int i = 0; i < 4; i++)
			issue_op(1'b0, 1'b1, AW'(8'ha0 + i), '0, 1'b0, 1'b0, TW'(i));
		wait_drained(1'b0);

		// load behind an uncommitted store whose data is still owed
		cdb_hold = 1'b1;
		issue_op(1'b1, 1'b1, 8'h30, 32'h5a5a_1234, 1'b0, 1'b1, '0);
		issue_op(1'b0, 1'b1, 8'h30, '0, 1'b0, 1'b0, 4'h7);
		repeat (4) begin
			idle_cycle();
			assert (!result_valid) else begin
				$display("FAIL %0t result_valid: got 1 expected 0", $time);
				errors++;
			end
		end
		cdb_hold = 1'b0;
		wait_drained(1'b0);

		// relative loads whose bases arrive later
		cdb_hold = 1'b1;
		issue_op(1'b0, 1'b0, 8'h30, '0, 1'b1, 1'b0, 4'h8);
		issue_op(1'b0, 1'b0, 8'h31, '0, 1'b1, 1'b0, 4'h9);
		repeat (3) idle_cycle();
		cdb_hold = 1'b0;
		wait_drained(1'b0);
		commit_mode = 1;
		wait_drained(1'b1);

		commit_mode = 2;
		ready_random = 1'b1;
		for (int i = 0; i < 400; i++) begin
			st = $urandom % 2;
			ab = $urandom % 2;
			a = AW'($urandom % 16);
			d = $urandom;
			bl = $urandom % 2;
			dl = $urandom % 2;
			issue_op(st, ab, a, d, bl, dl, TW'(i));
			if ($urandom % 8 == 0)
				idle_cycle();
		end
		wait_drained(1'b1);
		repeat (8) idle_cycle(); // a stray result would show here
		finish_run();
	end

endmodule
